// ==== common/pipeCtrlPkg.sv ====
// Pipeline hazard control package with instruction codes, classes and timing types
`default_nettype none

package pipeCtrlPkg;

    // Decoded instruction codes, NOP is the bubble value
    typedef enum logic [5:0] {
        NOP   = 6'd0,
        ADDU  = 6'd1,
        SUBU  = 6'd2,
        SLL   = 6'd3,
        SRL   = 6'd4,
        SRA   = 6'd5,
        CLO   = 6'd6,
        CLZ   = 6'd7,
        MOVN  = 6'd8,
        MOVZ  = 6'd9,
        ORI   = 6'd10,
        LUI   = 6'd11,
        LW    = 6'd12,
        LB    = 6'd13,
        SW    = 6'd14,
        BEQ   = 6'd15,
        BNE   = 6'd16,
        BLEZ  = 6'd17,
        J     = 6'd18,
        JAL   = 6'd19,
        JR    = 6'd20,
        JALR  = 6'd21,
        MULT  = 6'd22,
        MULTU = 6'd23,
        DIV   = 6'd24,
        DIVU  = 6'd25,
        MFHI  = 6'd26,
        MFLO  = 6'd27,
        MTHI  = 6'd28,
        MTLO  = 6'd29
    } instrCode_t;

    // Function classes used by the hazard rules
    typedef enum logic [2:0] {
        CALC_R    = 3'd0,
        CALC_I    = 3'd1,
        MEM_READ  = 3'd2,
        MEM_WRITE = 3'd3,
        BRANCH    = 3'd4,
        JUMP      = 3'd5,
        MULTDIV   = 3'd6,
        NONE      = 3'd7
    } funcClass_t;

    typedef logic [2:0] tval_t;     // Tuse or Tnew in cycles

    // Operand that is never read
    localparam tval_t TUSE_INF = 3'd7;

    typedef logic [4:0]  regAddr_t; // Register 0 is never a hazard
    typedef logic [31:0] pc_t;

    // Control code from CP0 toward NPC
    typedef enum logic [1:0] {
        NORMAL = 2'd0,
        KTEXT  = 2'd1,  // Exception entry
        ERET   = 2'd2   // Return from exception
    } kCtrl_t;

    typedef logic [3:0] mdCount_t;  // Multiply/divide busy countdown

endpackage

`default_nettype wire

// ==== hdl/instrClassify.sv ====
// Instruction classifier that maps a decoded instruction code to its function class
`timescale 1ns/10ps
`default_nettype none

module instrClassify import pipeCtrlPkg::*; (
    input  wire instrCode_t instr,
    output funcClass_t      func
);

    always_comb begin
        case (instr)
            ADDU, SUBU, SLL, SRL, SRA,
            CLO, CLZ, MOVN, MOVZ:        func = CALC_R;
            ORI, LUI:                    func = CALC_I;
            LW, LB:                      func = MEM_READ;
            SW:                          func = MEM_WRITE;
            BEQ, BNE, BLEZ:              func = BRANCH;
            J, JAL, JR, JALR:            func = JUMP;
            // HI/LO access counts as multiply/divide work
            MULT, MULTU, DIV, DIVU,
            MFHI, MFLO, MTHI, MTLO:      func = MULTDIV;
            NOP:                         func = NONE;
            default:                     func = NONE;   // Unused encodings
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/tuseTnewDecode.sv ====
// Tuse and Tnew decoder for the instruction sitting in ID
`timescale 1ns/10ps
`default_nettype none

module tuseTnewDecode import pipeCtrlPkg::*; (
    input  wire instrCode_t instr,
    output funcClass_t      func,
    output tval_t           tuseRs,
    output tval_t           tuseRt,
    output tval_t           tnewId  // Cycles until the result exists, seen from ID
);

    instrClassify uClassify (
        .instr (instr),
        .func  (func)
    );

    always_comb begin
        tuseRs = TUSE_INF;
        tuseRt = TUSE_INF;
        tnewId = 3'd0;
        if (instr inside {MOVN, MOVZ}) begin
            // Conditional move reads both operands right away
            tuseRs = 3'd0;
            tuseRt = 3'd0;
            tnewId = 3'd1;
        end else begin
            case (func)
                CALC_R: begin
                    tuseRs = (instr inside {SLL, SRL, SRA}) ? TUSE_INF : 3'd1;
                    tuseRt = (instr inside {CLO, CLZ}) ? TUSE_INF : 3'd1;
                    tnewId = 3'd2;
                end
                CALC_I: begin
                    tuseRs = (instr == LUI) ? TUSE_INF : 3'd1;
                    tnewId = (instr == LUI) ? 3'd1 : 3'd2;
                end
                MEM_READ: begin
                    tuseRs = 3'd1;
                    tnewId = (instr == LW) ? 3'd3 : 3'd5;   // LB has an extra align stage
                end
                MEM_WRITE: begin
                    tuseRs = 3'd1;
                    tuseRt = 3'd2;  // Store data needed only in MEM
                end
                BRANCH: begin
                    tuseRs = 3'd0;
                    tuseRt = (instr inside {BEQ, BNE}) ? 3'd0 : TUSE_INF;
                end
                JUMP: begin
                    tuseRs = (instr inside {JR, JALR}) ? 3'd0 : TUSE_INF;
                    tnewId = (instr inside {JAL, JALR}) ? 3'd1 : 3'd0;   // Link value
                end
                MULTDIV: begin
                    if (instr inside {MULT, MULTU, DIV, DIVU}) begin
                        tuseRs = 3'd1;
                        tuseRt = 3'd1;
                    end else if (instr inside {MTHI, MTLO}) begin
                        tuseRs = 3'd1;
                    end
                    tnewId = (instr inside {MFHI, MFLO}) ? 3'd2 : 3'd0;
                end
                default: begin
                    tuseRs = TUSE_INF;
                    tuseRt = TUSE_INF;
                    tnewId = 3'd0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/stageTracker.sv ====
// Stage tracker holding EX, MEM and WB registers with Tnew countdown, bubbles and flush
`timescale 1ns/10ps
`default_nettype none

module stageTracker import pipeCtrlPkg::*; (
    input  wire             clk,
    input  wire             arstN,
    input  wire instrCode_t instrId,
    input  wire regAddr_t   destId,
    input  wire tval_t      tnewId,
    input  wire pc_t        pcId,
    input  wire             stallId,
    input  wire             clrId,
    input  wire             clrEx,
    input  wire             clrMem,
    input  wire             clrWb,
    output instrCode_t      instrEx,
    output instrCode_t      instrWb,
    output regAddr_t        destEx,
    output regAddr_t        destMem,
    output tval_t           tnewEx,
    output tval_t           tnewMem,
    output pc_t             pcEx,
    output pc_t             pcMem,
    output pc_t             pcWb
);

    instrCode_t instrMem;
    logic       bubbleEx;

    // Tnew steps down by one per stage, never below zero
    function automatic tval_t decSat(input tval_t t);
        return (t == 3'd0) ? 3'd0 : t - 3'd1;
    endfunction

    // A held or squashed ID slot must not reach EX
    assign bubbleEx = clrEx | clrId | stallId;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrEx <= NOP;
            destEx  <= '0;
            tnewEx  <= '0;
            pcEx    <= '0;
        end else if (bubbleEx) begin
            instrEx <= NOP;
            destEx  <= '0;
            tnewEx  <= '0;
            pcEx    <= '0;
        end else begin
            instrEx <= instrId;
            destEx  <= destId;
            tnewEx  <= decSat(tnewId);
            pcEx    <= pcId;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrMem <= NOP;
            destMem  <= '0;
            tnewMem  <= '0;
            pcMem    <= '0;
        end else if (clrMem) begin
            instrMem <= NOP;
            destMem  <= '0;
            tnewMem  <= '0;
            pcMem    <= '0;
        end else begin
            instrMem <= instrEx;
            destMem  <= destEx;
            tnewMem  <= decSat(tnewEx);
            pcMem    <= pcEx;
        end
    end

    // WB only needs the code and PC, for the delay slot check
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrWb <= NOP;
            pcWb    <= '0;
        end else if (clrWb) begin
            instrWb <= NOP;
            pcWb    <= '0;
        end else begin
            instrWb <= instrMem;
            pcWb    <= pcMem;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/multDivTimer.sv ====
// Multiply/divide busy timer with separate multiply and divide latencies
`timescale 1ns/10ps
`default_nettype none

module multDivTimer import pipeCtrlPkg::*; #(
    parameter int MULT_CYCLES = 5,
    parameter int DIV_CYCLES  = 10
) (
    input  wire             clk,
    input  wire             arstN,
    input  wire instrCode_t instrEx,
    input  wire             disMultDiv,
    output logic            mdBusy
);

    mdCount_t mdCount;
    logic     startMult;
    logic     startDiv;

    // Start only when the unit is not disabled by a flush
    assign startMult = !disMultDiv && (instrEx inside {MULT, MULTU});
    assign startDiv  = !disMultDiv && (instrEx inside {DIV, DIVU});

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mdCount <= '0;
        end else if (startMult) begin
            mdCount <= mdCount_t'(MULT_CYCLES);
        end else if (startDiv) begin
            mdCount <= mdCount_t'(DIV_CYCLES);
        end else if (mdCount != '0) begin
            mdCount <= mdCount - 4'd1;  // Count down to idle
        end
    end

    assign mdBusy = (mdCount != '0);

endmodule

`default_nettype wire

// ==== pipelineControl/pipelineControl.sv ====
// Pipeline control for stalls, flush clears, unit disables, NPC control and macro PC
`timescale 1ns/10ps
`default_nettype none

module pipelineControl import pipeCtrlPkg::*; (
    input  wire instrCode_t instrId,
    input  wire instrCode_t instrWb,
    input  wire funcClass_t funcId,
    input  wire regAddr_t   rsId,
    input  wire regAddr_t   rtId,
    input  wire regAddr_t   destEx,
    input  wire regAddr_t   destMem,
    input  wire tval_t      tuseRs,
    input  wire tval_t      tuseRt,
    input  wire tval_t      tnewEx,
    input  wire tval_t      tnewMem,
    input  wire             mdBusy,
    input  wire kCtrl_t     kCtrlCp0,
    input  wire pc_t        pcIf,
    input  wire pc_t        pcId,
    input  wire pc_t        pcEx,
    input  wire pc_t        pcMem,
    input  wire pc_t        pcWb,
    output logic            stallPc,
    output logic            stallId,
    output logic            clrId,
    output logic            clrEx,
    output logic            clrMem,
    output logic            clrWb,
    output logic            disMultDiv,
    output logic            disDm,
    output kCtrl_t          kCtrlNpc,
    output pc_t             macroPc
);

    funcClass_t funcWb;
    logic       stallRs;
    logic       stallRt;
    logic       stallMd;
    logic       hazard;
    logic       flush;

    // Class of the WB instruction tells whether it owns a delay slot
    instrClassify uClassifyWb (
        .instr (instrWb),
        .func  (funcWb)
    );

    // Operand needed before the producer in EX or MEM has it
    assign stallRs = (instrId != NOP) && (rsId != '0) &&
                     ((destEx == rsId && tnewEx > tuseRs) ||
                      (destMem == rsId && tnewMem > tuseRs));
    assign stallRt = (instrId != NOP) && (rtId != '0) &&
                     ((destEx == rtId && tnewEx > tuseRt) ||
                      (destMem == rtId && tnewMem > tuseRt));

    assign stallMd = mdBusy && (funcId == MULTDIV);   // HI/LO still in use
    assign hazard  = stallRs | stallRt | stallMd;

    assign flush = (kCtrlCp0 == KTEXT) || (kCtrlCp0 == ERET);

    // Flush wins over any pending stall
    assign stallPc = hazard && !flush;
    assign stallId = hazard && !flush;

    assign clrId      = flush;
    assign clrEx      = hazard | flush;  // Bubble or flush
    assign clrMem     = flush;
    assign clrWb      = flush;
    assign disMultDiv = flush;
    assign disDm      = flush;
    assign kCtrlNpc   = kCtrlCp0;

    // Oldest valid PC, or the branch PC if WB holds a delay slot owner
    always_comb begin
        if (funcWb == BRANCH || funcWb == JUMP) begin
            macroPc = pcWb;
        end else if (pcMem != '0) begin
            macroPc = pcMem;
        end else if (pcEx != '0) begin
            macroPc = pcEx;
        end else if (pcId != '0) begin
            macroPc = pcId;
        end else if (pcIf != '0) begin
            macroPc = pcIf;
        end else begin
            macroPc = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/hazardTop.sv ====
// Hazard control top level joining decoder, stage tracker, multiply/divide timer and control
`timescale 1ns/10ps
`default_nettype none

module hazardTop import pipeCtrlPkg::*; #(
    parameter int MULT_CYCLES = 5,
    parameter int DIV_CYCLES  = 10
) (
    input  wire             clk,
    input  wire             arstN,
    input  wire instrCode_t instrId,
    input  wire regAddr_t   rsId,
    input  wire regAddr_t   rtId,
    input  wire regAddr_t   destId,
    input  wire pc_t        pcIf,
    input  wire pc_t        pcId,
    input  wire kCtrl_t     kCtrlCp0,
    output logic            stallPc,
    output logic            stallId,
    output logic            disDm,
    output kCtrl_t          kCtrlNpc,
    output pc_t             macroPc
);

    funcClass_t funcId;
    tval_t      tuseRs;
    tval_t      tuseRt;
    tval_t      tnewId;
    tval_t      tnewEx;
    tval_t      tnewMem;
    instrCode_t instrEx;
    instrCode_t instrWb;
    regAddr_t   destEx;
    regAddr_t   destMem;
    pc_t        pcEx;
    pc_t        pcMem;
    pc_t        pcWb;
    logic       clrId;
    logic       clrEx;
    logic       clrMem;
    logic       clrWb;
    logic       disMultDiv;
    logic       mdBusy;

    tuseTnewDecode uDecode (
        .instr  (instrId),
        .func   (funcId),
        .tuseRs (tuseRs),
        .tuseRt (tuseRt),
        .tnewId (tnewId)
    );

    stageTracker uTracker (
        .clk     (clk),
        .arstN   (arstN),
        .instrId (instrId),
        .destId  (destId),
        .tnewId  (tnewId),
        .pcId    (pcId),
        .stallId (stallId),
        .clrId   (clrId),
        .clrEx   (clrEx),
        .clrMem  (clrMem),
        .clrWb   (clrWb),
        .instrEx (instrEx),
        .instrWb (instrWb),
        .destEx  (destEx),
        .destMem (destMem),
        .tnewEx  (tnewEx),
        .tnewMem (tnewMem),
        .pcEx    (pcEx),
        .pcMem   (pcMem),
        .pcWb    (pcWb)
    );

    multDivTimer #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) uMdTimer (
        .clk        (clk),
        .arstN      (arstN),
        .instrEx    (instrEx),
        .disMultDiv (disMultDiv),
        .mdBusy     (mdBusy)
    );

    pipelineControl uControl (
        .instrId    (instrId),
        .instrWb    (instrWb),
        .funcId     (funcId),
        .rsId       (rsId),
        .rtId       (rtId),
        .destEx     (destEx),
        .destMem    (destMem),
        .tuseRs     (tuseRs),
        .tuseRt     (tuseRt),
        .tnewEx     (tnewEx),
        .tnewMem    (tnewMem),
        .mdBusy     (mdBusy),
        .kCtrlCp0   (kCtrlCp0),
        .pcIf       (pcIf),
        .pcId       (pcId),
        .pcEx       (pcEx),
        .pcMem      (pcMem),
        .pcWb       (pcWb),
        .stallPc    (stallPc),
        .stallId    (stallId),
        .clrId      (clrId),
        .clrEx      (clrEx),
        .clrMem     (clrMem),
        .clrWb      (clrWb),
        .disMultDiv (disMultDiv),
        .disDm      (disDm),
        .kCtrlNpc   (kCtrlNpc),
        .macroPc    (macroPc)
    );

endmodule

`default_nettype wire

// ==== verification/tbHazard.sv ====
// Directed testbench for the pipeline hazard, multiply/divide stall and flush control
`timescale 1ns/10ps
`default_nettype none

module tbHazard import pipeCtrlPkg::*; ();

    localparam int MULT_CYCLES = 5;
    localparam int DIV_CYCLES  = 10;
    localparam int WAIT_LIMIT  = 40;    // Cycles before a wait gives up

    logic       clk = 1'b0;
    logic       arstN;
    instrCode_t instrId;
    regAddr_t   rsId;
    regAddr_t   rtId;
    regAddr_t   destId;
    pc_t        pcIf;
    pc_t        pcId;
    kCtrl_t     kCtrlCp0;
    logic       stallPc;
    logic       stallId;
    logic       disDm;
    kCtrl_t     kCtrlNpc;
    pc_t        macroPc;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    // Expected EX/MEM/WB contents for the macro PC walk
    instrCode_t shInsEx;
    instrCode_t shInsMem;
    instrCode_t shInsWb;
    pc_t        shPcEx;
    pc_t        shPcMem;
    pc_t        shPcWb;

    hazardTop #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) u_dut (
        .clk      (clk),
        .arstN    (arstN),
        .instrId  (instrId),
        .rsId     (rsId),
        .rtId     (rtId),
        .destId   (destId),
        .pcIf     (pcIf),
        .pcId     (pcId),
        .kCtrlCp0 (kCtrlCp0),
        .stallPc  (stallPc),
        .stallId  (stallId),
        .disDm    (disDm),
        .kCtrlNpc (kCtrlNpc),
        .macroPc  (macroPc)
    );

    always #10 clk = ~clk;

    // Reference Tnew at ID
    function automatic int refTnewId(input instrCode_t ins);
        case (ins)
            MOVN, MOVZ, LUI, JAL, JALR:             return 1;
            ADDU, SUBU, SLL, SRL, SRA, CLO, CLZ,
            ORI, MFHI, MFLO:                        return 2;
            LW:                                     return 3;
            LB:                                     return 5;   // Extra align stage
            default:                                return 0;
        endcase
    endfunction

    function automatic int refTuseRs(input instrCode_t ins);
        case (ins)
            MOVN, MOVZ, BEQ, BNE, BLEZ, JR, JALR:   return 0;
            ADDU, SUBU, CLO, CLZ, ORI, LW, LB, SW,
            MULT, MULTU, DIV, DIVU, MTHI, MTLO:     return 1;
            default:                                return int'(TUSE_INF);
        endcase
    endfunction

    function automatic int refTuseRt(input instrCode_t ins);
        case (ins)
            MOVN, MOVZ, BEQ, BNE:                   return 0;
            ADDU, SUBU, SLL, SRL, SRA,
            MULT, MULTU, DIV, DIVU:                 return 1;
            SW:                                     return 2;
            default:                                return int'(TUSE_INF);
        endcase
    endfunction

    // Stall cycles of a reader issued right behind its producer
    function automatic int operandStalls(input instrCode_t prod, input regAddr_t dest,
                                         input regAddr_t src, input int tuse);
        int tnew;
        int count;
        int stage;
        tnew  = (refTnewId(prod) > 0) ? refTnewId(prod) - 1 : 0;
        count = 0;
        if (dest == 5'd0 || dest != src) begin
            return 0;
        end
        // Producer is compared in EX, then in MEM
        for (stage = 0; stage < 2; stage++) begin
            if (tnew <= tuse) begin
                break;
            end
            count++;
            tnew = tnew - 1;
        end
        return count;
    endfunction

    // HI/LO user issued gap slots after a multiply or divide
    function automatic int hiLoStalls(input instrCode_t prod, input int gap,
                                      input instrCode_t cons);
        int busy;
        busy = (prod inside {MULT, MULTU}) ? MULT_CYCLES :
               (prod inside {DIV, DIVU})   ? DIV_CYCLES  : 0;
        if (!(cons inside {MULT, MULTU, DIV, DIVU, MFHI, MFLO, MTHI, MTLO})) begin
            return 0;
        end
        if (gap == 0) begin
            return 0;   // Busy rises only after the start has left ID
        end
        return (busy - gap + 1 > 0) ? busy - gap + 1 : 0;
    endfunction

    function automatic bit isDelayOwner(input instrCode_t ins);
        return ins inside {BEQ, BNE, BLEZ, J, JAL, JR, JALR};
    endfunction

    function automatic pc_t macroModel(input instrCode_t insWb, input pc_t wb, input pc_t mem,
                                       input pc_t ex, input pc_t id, input pc_t fetch);
        if (isDelayOwner(insWb)) begin
            return wb;
        end
        if (mem != '0) begin
            return mem;
        end
        if (ex != '0) begin
            return ex;
        end
        if (id != '0) begin
            return id;
        end
        return fetch;   // Zero when the pipe is empty
    endfunction

    task automatic checkCount(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkTval(input tval_t got, input tval_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkPc(input pc_t got, input pc_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkKctrl(input kCtrl_t got, input kCtrl_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic endRun();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // Presents one instruction in ID and counts the cycles it is held there
    task automatic issue(input instrCode_t ins, input regAddr_t rs, input regAddr_t rt,
                         input regAddr_t dest, input pc_t pc,
                         output int stalls, output tval_t exTnew);
        int waited;
        stalls  = 0;
        waited  = 0;
        instrId <= ins;
        rsId    <= rs;
        rtId    <= rt;
        destId  <= dest;
        pcId    <= pc;
        @(negedge clk);
        exTnew = u_dut.tnewEx;  // Producer sitting in EX
        while (stallId && waited < WAIT_LIMIT) begin
            stalls++;
            waited++;
            @(negedge clk);
        end
        if (stallId) begin
            timeouts++;
            $display("Timeout: %s at pc %h still stalled after %0d cycles",
                     ins.name(), pc, WAIT_LIMIT);
            endRun();
        end else begin
            @(posedge clk);     // Slot leaves ID here
        end
    endtask

    task automatic drain(input int slots);
        int    s;
        tval_t t;
        repeat (slots) begin
            issue(NOP, 5'd0, 5'd0, 5'd0, '0, s, t);
        end
    endtask

    task automatic loadUseTest();
        int    s;
        tval_t t;
        drain(3);
        issue(LW, 5'd1, 5'd0, 5'd5, 32'h100, s, t);
        checkCount(s, 0, "LW issue");
        issue(ADDU, 5'd5, 5'd2, 5'd6, 32'h104, s, t);
        checkTval(t, tval_t'(refTnewId(LW) - 1), "LW Tnew in EX");
        checkCount(s, operandStalls(LW, 5'd5, 5'd5, refTuseRs(ADDU)), "ADDU after LW");
        drain(3);
        issue(LB, 5'd1, 5'd0, 5'd5, 32'h110, s, t);
        issue(ADDU, 5'd5, 5'd2, 5'd6, 32'h114, s, t);
        checkTval(t, tval_t'(refTnewId(LB) - 1), "LB Tnew in EX");
        checkCount(s, operandStalls(LB, 5'd5, 5'd5, refTuseRs(ADDU)), "ADDU after LB");
        drain(3);
        issue(LW, 5'd1, 5'd0, 5'd0, 32'h120, s, t);
        issue(ADDU, 5'd0, 5'd2, 5'd6, 32'h124, s, t);
        checkCount(s, operandStalls(LW, 5'd0, 5'd0, refTuseRs(ADDU)), "ADDU reading r0");
    endtask

    task automatic branchTest();
        int    s;
        tval_t t;
        drain(3);
        issue(ADDU, 5'd1, 5'd2, 5'd7, 32'h200, s, t);
        issue(BEQ, 5'd7, 5'd8, 5'd0, 32'h204, s, t);
        checkCount(s, operandStalls(ADDU, 5'd7, 5'd7, refTuseRs(BEQ)), "BEQ after ADDU");
        drain(3);
        issue(LW, 5'd1, 5'd0, 5'd7, 32'h210, s, t);
        issue(BEQ, 5'd7, 5'd8, 5'd0, 32'h214, s, t);
        checkCount(s, operandStalls(LW, 5'd7, 5'd7, refTuseRs(BEQ)), "BEQ after LW");
        drain(3);
        issue(LW, 5'd1, 5'd0, 5'd9, 32'h220, s, t);
        issue(SW, 5'd1, 5'd9, 5'd0, 32'h224, s, t);    // Store data in rt
        checkCount(s, operandStalls(LW, 5'd9, 5'd9, refTuseRt(SW)), "SW data after LW");
    endtask

    task automatic multDivTest();
        int    s;
        tval_t t;
        drain(3);
        issue(MULT, 5'd1, 5'd2, 5'd0, 32'h300, s, t);
        issue(NOP, 5'd0, 5'd0, 5'd0, 32'h304, s, t);
        issue(MFLO, 5'd0, 5'd0, 5'd10, 32'h308, s, t);
        checkCount(s, hiLoStalls(MULT, 1, MFLO), "MFLO after MULT");
        issue(DIV, 5'd3, 5'd4, 5'd0, 32'h30c, s, t);
        checkCount(s, 0, "DIV with unit idle");
        issue(NOP, 5'd0, 5'd0, 5'd0, 32'h310, s, t);
        issue(MFHI, 5'd0, 5'd0, 5'd12, 32'h314, s, t);
        checkCount(s, hiLoStalls(DIV, 1, MFHI), "MFHI after DIV");
        issue(MULT, 5'd1, 5'd2, 5'd0, 32'h318, s, t);
        issue(NOP, 5'd0, 5'd0, 5'd0, 32'h31c, s, t);
        // ADDU sits in ID while the unit is busy
        issue(ADDU, 5'd3, 5'd4, 5'd11, 32'h320, s, t);
        checkCount(s, hiLoStalls(MULT, 1, ADDU), "ADDU after MULT");
    endtask

    task automatic flushTest();
        int    s;
        tval_t t;
        drain(4);
        issue(LB, 5'd1, 5'd0, 5'd5, 32'h400, s, t);
        // ADDU waits on the LB result
        instrId <= ADDU;
        rsId    <= 5'd5;
        rtId    <= 5'd2;
        destId  <= 5'd6;
        pcId    <= 32'h404;
        @(negedge clk);
        checkBit(stallId, 1'b1, "stallId before flush");
        checkBit(disDm, 1'b0, "disDm before flush");
        @(posedge clk);
        kCtrlCp0 <= KTEXT;      // Exception entry while ADDU is still held
        @(negedge clk);
        checkBit(stallId, 1'b0, "stallId masked by flush");
        checkBit(stallPc, 1'b0, "stallPc masked by flush");
        checkBit(disDm, 1'b1, "disDm during flush");
        checkKctrl(kCtrlNpc, KTEXT, "kCtrlNpc during flush");
        @(posedge clk);
        kCtrlCp0 <= NORMAL;
        // Squashed ADDU never reaches EX, so nothing in flight writes r6
        issue(BEQ, 5'd6, 5'd0, 5'd0, 32'h8000_0180, s, t);
        checkCount(s, 0, "BEQ on r6 after flush");
    endtask

    // One unstalled slot with a macro PC check against the shadow stages
    task automatic stepMacro(input instrCode_t ins, input regAddr_t dest, input pc_t pc,
                             input pc_t fetchPc);
        pc_t expPc;
        instrId <= ins;
        rsId    <= 5'd0;
        rtId    <= 5'd0;
        destId  <= dest;
        pcId    <= pc;
        pcIf    <= fetchPc;
        expPc   = macroModel(shInsWb, shPcWb, shPcMem, shPcEx, pc, fetchPc);
        @(negedge clk);
        checkBit(stallId, 1'b0, "no stall in PC walk");
        checkPc(macroPc, expPc, "macroPc");
        @(posedge clk);
        shInsWb  = shInsMem;
        shPcWb   = shPcMem;
        shInsMem = shInsEx;
        shPcMem  = shPcEx;
        shInsEx  = ins;
        shPcEx   = pc;
    endtask

    task automatic macroPcTest();
        pcIf <= '0;
        drain(3);
        shInsEx  = NOP;
        shInsMem = NOP;
        shInsWb  = NOP;
        shPcEx   = '0;
        shPcMem  = '0;
        shPcWb   = '0;
        stepMacro(NOP, 5'd0, 32'h0, 32'h3000);
        stepMacro(ORI, 5'd8, 32'h3000, 32'h3004);
        stepMacro(JAL, 5'd31, 32'h3004, 32'h3008);
        stepMacro(ORI, 5'd9, 32'h3008, 32'h300c);
        stepMacro(NOP, 5'd0, 32'h0, 32'h3010);
        stepMacro(NOP, 5'd0, 32'h0, 32'h3014);  // JAL reaches WB
        stepMacro(NOP, 5'd0, 32'h0, 32'h0);
    endtask

    initial begin
        arstN    <= 1'b0;
        instrId  <= NOP;
        rsId     <= '0;
        rtId     <= '0;
        destId   <= '0;
        pcIf     <= '0;
        pcId     <= '0;
        kCtrlCp0 <= NORMAL;
        repeat (16) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkBit(stallId, 1'b0, "stallId after reset");
        checkBit(stallPc, 1'b0, "stallPc after reset");
        checkBit(disDm, 1'b0, "disDm after reset");
        checkKctrl(kCtrlNpc, NORMAL, "kCtrlNpc after reset");
        @(posedge clk);
        loadUseTest();
        branchTest();
        multDivTest();
        flushTest();
        macroPcTest();
        endRun();
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/pipeCtrlPkg.sv
hdl/instrClassify.sv
hdl/tuseTnewDecode.sv
hdl/stageTracker.sv
hdl/multDivTimer.sv
pipelineControl/pipelineControl.sv
hdl/hazardTop.sv
verification/tbHazard.sv

// ==== Makefile ====
# Verilator build and run of the hazard control testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/10ps -Wno-fatal -j 0
TOP       = tbHazard
FILELIST  = all.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/10ps -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
